// ==== verilog/mbx_pkg.sv ====
package mbx_pkg;

    // Bus and memory widths
    typedef logic [7:0]  wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [5:0]  sram_addr_t;
    typedef logic [6:0]  dlen_t;
    typedef logic [4:0]  status_t;

    // Register map, word addresses
    localparam wb_addr_t REG_FUSE_BASE    = 8'h00;
    localparam wb_addr_t REG_FUSE_DONE    = 8'h10;
    localparam wb_addr_t REG_STATUS       = 8'h11;
    localparam wb_addr_t REG_MBOX_LOCK    = 8'h12;
    localparam wb_addr_t REG_MBOX_DLEN    = 8'h13;
    localparam wb_addr_t REG_MBOX_DATAIN  = 8'h14;
    localparam wb_addr_t REG_MBOX_DATAOUT = 8'h15;
    localparam wb_addr_t REG_MBOX_EXECUTE = 8'h16;
    localparam wb_addr_t REG_ERROR        = 8'h17;

    // STATUS bit positions
    localparam int STAT_RDY_FUSES = 0;
    localparam int STAT_RDY_MB    = 1;
    localparam int STAT_LOCK      = 2;
    localparam int STAT_AVAIL     = 3;
    localparam int STAT_ERR       = 4;

    // Boot sequencer states
    typedef enum logic [2:0] {
        BOOT_IDLE,
        BOOT_FUSES,
        BOOT_HOLD,
        BOOT_INIT,
        BOOT_READY
    } boot_state_t;

endpackage

// ==== verilog/mbx_wb_slave.sv ====
`timescale 1ns/1ps

module mbx_wb_slave #(
    parameter int NUM_FUSE_WORDS = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  mbx_pkg::wb_addr_t wb_adr,
    input  mbx_pkg::wb_data_t wb_dat_w,
    output mbx_pkg::wb_data_t wb_dat_r,
    output logic              wb_ack,
    output logic              fuse_wr,
    output logic              fuse_rd,
    output logic              done_wr,
    output logic              mbox_lock_rd,
    output logic              mbox_dlen_wr,
    output logic              mbox_din_wr,
    output logic              mbox_dout_rd,
    output logic              mbox_exec_wr,
    output logic              err_clr,
    output mbx_pkg::wb_addr_t reg_offset,
    output mbx_pkg::wb_data_t reg_wdata,
    input  mbx_pkg::wb_data_t fuse_rdata,
    input  mbx_pkg::wb_data_t mbox_rdata,
    input  logic              mbox_rdata_valid,
    input  mbx_pkg::status_t  status_bits
);

    logic              accept;
    logic              is_fuse;
    logic              dout_wait;
    mbx_pkg::wb_data_t rd_mux;

    // One access in flight, no new accept during ack or a DATAOUT wait
    assign accept  = wb_cyc && wb_stb && !wb_ack && !dout_wait;

    assign reg_offset = wb_adr - mbx_pkg::REG_FUSE_BASE;
    assign reg_wdata  = wb_dat_w;
    assign is_fuse    = reg_offset < mbx_pkg::wb_addr_t'(NUM_FUSE_WORDS);

    assign fuse_wr      = accept && wb_we && is_fuse;
    assign fuse_rd      = accept && !wb_we && is_fuse;
    assign done_wr      = accept && wb_we && (wb_adr == mbx_pkg::REG_FUSE_DONE);
    assign mbox_lock_rd = accept && !wb_we && (wb_adr == mbx_pkg::REG_MBOX_LOCK);
    assign mbox_dlen_wr = accept && wb_we && (wb_adr == mbx_pkg::REG_MBOX_DLEN);
    assign mbox_din_wr  = accept && wb_we && (wb_adr == mbx_pkg::REG_MBOX_DATAIN);
    assign mbox_dout_rd = accept && !wb_we && (wb_adr == mbx_pkg::REG_MBOX_DATAOUT);
    assign mbox_exec_wr = accept && wb_we && (wb_adr == mbx_pkg::REG_MBOX_EXECUTE);
    assign err_clr      = accept && wb_we && (wb_adr == mbx_pkg::REG_ERROR);

    // Single-cycle read sources, write-only and unmapped words read zero
    always_comb
    begin
        rd_mux = '0;
        if (is_fuse)
        begin
            rd_mux = fuse_rdata;
        end
        else
        begin
            case (wb_adr)
                mbx_pkg::REG_STATUS:    rd_mux = mbx_pkg::wb_data_t'(status_bits);
                mbx_pkg::REG_MBOX_LOCK: rd_mux = mbox_rdata;
                mbx_pkg::REG_ERROR:     rd_mux = mbx_pkg::wb_data_t'(status_bits[mbx_pkg::STAT_ERR]);
                default:                rd_mux = '0;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb_ack    <= 1'b0;
            wb_dat_r  <= '0;
            dout_wait <= 1'b0;
        end
        else
        begin
            wb_ack <= 1'b0;
            if (mbox_dout_rd)
            begin
                dout_wait <= 1'b1;
            end
            else if (accept)
            begin
                wb_ack   <= 1'b1;
                wb_dat_r <= wb_we ? '0 : rd_mux;
            end
            // SRAM word arrives one cycle after the DATAOUT strobe
            if (dout_wait && mbox_rdata_valid)
            begin
                wb_ack    <= 1'b1;
                wb_dat_r  <= mbox_rdata;
                dout_wait <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/mbx_fuse_bank.sv ====
`timescale 1ns/1ps

module mbx_fuse_bank #(
    parameter int NUM_FUSE_WORDS = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              fuse_wr,
    input  logic              fuse_rd,
    input  logic              done_wr,
    input  mbx_pkg::wb_addr_t reg_offset,
    input  mbx_pkg::wb_data_t reg_wdata,
    output mbx_pkg::wb_data_t fuse_rdata,
    output logic              fuses_locked,
    output logic              fuse_err
);

    localparam int IDX_W = (NUM_FUSE_WORDS > 1) ? $clog2(NUM_FUSE_WORDS) : 1;

    mbx_pkg::wb_data_t fuse_q [NUM_FUSE_WORDS];
    logic [IDX_W-1:0]  idx;

    // Slave only strobes offsets inside the bank
    assign idx = reg_offset[IDX_W-1:0];

    assign fuse_rdata = fuse_rd ? fuse_q[idx] : '0;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < NUM_FUSE_WORDS; i++)
            begin
                fuse_q[i] <= '0;
            end
        end
        else if (fuse_wr && !fuses_locked)
        begin
            fuse_q[idx] <= reg_wdata;
        end
    end

    // Lock is sticky until reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fuses_locked <= 1'b0;
            fuse_err     <= 1'b0;
        end
        else
        begin
            if (done_wr && reg_wdata[0])
            begin
                fuses_locked <= 1'b1;
            end
            // Late write is dropped and flagged for one cycle
            fuse_err <= fuse_wr && fuses_locked;
        end
    end

endmodule

// ==== verilog/mbx_boot_fsm.sv ====
`timescale 1ns/1ps

module mbx_boot_fsm #(
    parameter int BOOT_CYCLES = 20
) (
    input  logic clk,
    input  logic reset,
    input  logic fuses_locked,
    input  logic boot_brkpoint,
    output logic ready_for_fuses,
    output logic ready_for_mb_processing
);

    localparam int CNT_W = $clog2(BOOT_CYCLES + 1);

    mbx_pkg::boot_state_t state;
    mbx_pkg::boot_state_t state_next;
    logic [CNT_W-1:0]     cnt;

    always_comb
    begin
        state_next = state;
        case (state)
            mbx_pkg::BOOT_IDLE:
                state_next = mbx_pkg::BOOT_FUSES;
            mbx_pkg::BOOT_FUSES:
            begin
                // Hold only entered while the breakpoint strap is set
                if (fuses_locked)
                begin
                    state_next = boot_brkpoint ? mbx_pkg::BOOT_HOLD : mbx_pkg::BOOT_INIT;
                end
            end
            mbx_pkg::BOOT_HOLD:
            begin
                if (!boot_brkpoint)
                begin
                    state_next = mbx_pkg::BOOT_INIT;
                end
            end
            mbx_pkg::BOOT_INIT:
            begin
                if (cnt == CNT_W'(BOOT_CYCLES - 1))
                begin
                    state_next = mbx_pkg::BOOT_READY;
                end
            end
            default:
                state_next = mbx_pkg::BOOT_READY;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= mbx_pkg::BOOT_IDLE;
            cnt   <= '0;
        end
        else
        begin
            state <= state_next;
            cnt   <= (state == mbx_pkg::BOOT_INIT) ? cnt + 1'b1 : '0;
        end
    end

    // Moore outputs, mutually exclusive by state
    assign ready_for_fuses         = (state == mbx_pkg::BOOT_FUSES);
    assign ready_for_mb_processing = (state == mbx_pkg::BOOT_READY);

endmodule

// ==== verilog/mbx_mailbox.sv ====
`timescale 1ns/1ps

module mbx_mailbox (
    input  logic                clk,
    input  logic                reset,
    input  logic                mb_ready,
    input  logic                mbox_lock_rd,
    input  logic                mbox_dlen_wr,
    input  logic                mbox_din_wr,
    input  logic                mbox_dout_rd,
    input  logic                mbox_exec_wr,
    input  logic                err_clr,
    input  mbx_pkg::wb_data_t   reg_wdata,
    input  logic                fuse_err,
    output mbx_pkg::wb_data_t   mbox_rdata,
    output logic                mbox_rdata_valid,
    output logic                lock_held,
    output logic                mailbox_data_avail,
    output logic                error_non_fatal,
    output logic                mbox_sram_cs,
    output logic                mbox_sram_we,
    output mbx_pkg::sram_addr_t mbox_sram_addr,
    output mbx_pkg::wb_data_t   mbox_sram_wdata,
    input  mbx_pkg::wb_data_t   mbox_sram_rdata
);

    mbx_pkg::sram_addr_t wr_ptr;
    mbx_pkg::dlen_t      rd_ptr;
    mbx_pkg::dlen_t      dlen;
    logic                lock_busy;
    logic                din_ok;
    logic                dout_hit;
    logic                dout_hit_q;
    logic                exec_clear;

    // Lock read returns 1 when busy or the boot flow is not done
    assign lock_busy  = lock_held || !mb_ready;
    assign din_ok     = mbox_din_wr && lock_held;
    assign dout_hit   = mbox_dout_rd && (rd_ptr < dlen);
    assign exec_clear = mbox_exec_wr && !reg_wdata[0];

    // SRAM request is issued in the strobe cycle
    assign mbox_sram_cs    = din_ok || dout_hit;
    assign mbox_sram_we    = din_ok;
    assign mbox_sram_addr  = din_ok ? wr_ptr : mbx_pkg::sram_addr_t'(rd_ptr);
    assign mbox_sram_wdata = reg_wdata;

    // Past DLEN the word reads as zero
    assign mbox_rdata = mbox_rdata_valid ? (dout_hit_q ? mbox_sram_rdata : '0)
                                         : mbx_pkg::wb_data_t'(lock_busy);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lock_held          <= 1'b0;
            mailbox_data_avail <= 1'b0;
            wr_ptr             <= '0;
            rd_ptr             <= '0;
            dlen               <= '0;
        end
        else
        begin
            if (mbox_lock_rd && !lock_busy)
            begin
                lock_held <= 1'b1;
            end
            if (mbox_dlen_wr && lock_held)
            begin
                dlen <= mbx_pkg::dlen_t'(reg_wdata);
            end
            if (din_ok)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (dout_hit)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (mbox_exec_wr && reg_wdata[0])
            begin
                mailbox_data_avail <= 1'b1;
            end
            // Execute cleared ends the transfer and frees the mailbox
            if (exec_clear)
            begin
                mailbox_data_avail <= 1'b0;
                lock_held          <= 1'b0;
                wr_ptr             <= '0;
                rd_ptr             <= '0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mbox_rdata_valid <= 1'b0;
            dout_hit_q       <= 1'b0;
            error_non_fatal  <= 1'b0;
        end
        else
        begin
            mbox_rdata_valid <= mbox_dout_rd;
            dout_hit_q       <= dout_hit;
            // New error events win over a clear in the same cycle
            if (fuse_err || (mbox_din_wr && !lock_held))
            begin
                error_non_fatal <= 1'b1;
            end
            else if (err_clr)
            begin
                error_non_fatal <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/mbx_top.sv ====
`timescale 1ns/1ps

module mbx_top #(
    parameter int NUM_FUSE_WORDS = 8,
    parameter int BOOT_CYCLES    = 20
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  mbx_pkg::wb_addr_t   wb_adr,
    input  mbx_pkg::wb_data_t   wb_dat_w,
    output mbx_pkg::wb_data_t   wb_dat_r,
    output logic                wb_ack,
    input  logic                boot_brkpoint,
    output logic                ready_for_fuses,
    output logic                ready_for_mb_processing,
    output logic                mailbox_data_avail,
    output logic                error_non_fatal,
    output logic                mbox_sram_cs,
    output logic                mbox_sram_we,
    output mbx_pkg::sram_addr_t mbox_sram_addr,
    output mbx_pkg::wb_data_t   mbox_sram_wdata,
    input  mbx_pkg::wb_data_t   mbox_sram_rdata
);

    logic              fuse_wr;
    logic              fuse_rd;
    logic              done_wr;
    logic              mbox_lock_rd;
    logic              mbox_dlen_wr;
    logic              mbox_din_wr;
    logic              mbox_dout_rd;
    logic              mbox_exec_wr;
    logic              err_clr;
    mbx_pkg::wb_addr_t reg_offset;
    mbx_pkg::wb_data_t reg_wdata;
    mbx_pkg::wb_data_t fuse_rdata;
    mbx_pkg::wb_data_t mbox_rdata;
    logic              mbox_rdata_valid;
    logic              fuses_locked;
    logic              fuse_err;
    logic              lock_held;
    mbx_pkg::status_t  status_bits;

    assign status_bits[mbx_pkg::STAT_RDY_FUSES] = ready_for_fuses;
    assign status_bits[mbx_pkg::STAT_RDY_MB]    = ready_for_mb_processing;
    assign status_bits[mbx_pkg::STAT_LOCK]      = lock_held;
    assign status_bits[mbx_pkg::STAT_AVAIL]     = mailbox_data_avail;
    assign status_bits[mbx_pkg::STAT_ERR]       = error_non_fatal;

    mbx_wb_slave #(
        .NUM_FUSE_WORDS (NUM_FUSE_WORDS)
    ) i_wb_slave (
        .clk              (clk),
        .reset            (reset),
        .wb_cyc           (wb_cyc),
        .wb_stb           (wb_stb),
        .wb_we            (wb_we),
        .wb_adr           (wb_adr),
        .wb_dat_w         (wb_dat_w),
        .wb_dat_r         (wb_dat_r),
        .wb_ack           (wb_ack),
        .fuse_wr          (fuse_wr),
        .fuse_rd          (fuse_rd),
        .done_wr          (done_wr),
        .mbox_lock_rd     (mbox_lock_rd),
        .mbox_dlen_wr     (mbox_dlen_wr),
        .mbox_din_wr      (mbox_din_wr),
        .mbox_dout_rd     (mbox_dout_rd),
        .mbox_exec_wr     (mbox_exec_wr),
        .err_clr          (err_clr),
        .reg_offset       (reg_offset),
        .reg_wdata        (reg_wdata),
        .fuse_rdata       (fuse_rdata),
        .mbox_rdata       (mbox_rdata),
        .mbox_rdata_valid (mbox_rdata_valid),
        .status_bits      (status_bits)
    );

    mbx_fuse_bank #(
        .NUM_FUSE_WORDS (NUM_FUSE_WORDS)
    ) i_fuse_bank (
        .clk          (clk),
        .reset        (reset),
        .fuse_wr      (fuse_wr),
        .fuse_rd      (fuse_rd),
        .done_wr      (done_wr),
        .reg_offset   (reg_offset),
        .reg_wdata    (reg_wdata),
        .fuse_rdata   (fuse_rdata),
        .fuses_locked (fuses_locked),
        .fuse_err     (fuse_err)
    );

    mbx_boot_fsm #(
        .BOOT_CYCLES (BOOT_CYCLES)
    ) i_boot_fsm (
        .clk                     (clk),
        .reset                   (reset),
        .fuses_locked            (fuses_locked),
        .boot_brkpoint           (boot_brkpoint),
        .ready_for_fuses         (ready_for_fuses),
        .ready_for_mb_processing (ready_for_mb_processing)
    );

    // Mailbox opens to the SoC once boot is done
    mbx_mailbox i_mailbox (
        .clk                (clk),
        .reset              (reset),
        .mb_ready           (ready_for_mb_processing),
        .mbox_lock_rd       (mbox_lock_rd),
        .mbox_dlen_wr       (mbox_dlen_wr),
        .mbox_din_wr        (mbox_din_wr),
        .mbox_dout_rd       (mbox_dout_rd),
        .mbox_exec_wr       (mbox_exec_wr),
        .err_clr            (err_clr),
        .reg_wdata          (reg_wdata),
        .fuse_err           (fuse_err),
        .mbox_rdata         (mbox_rdata),
        .mbox_rdata_valid   (mbox_rdata_valid),
        .lock_held          (lock_held),
        .mailbox_data_avail (mailbox_data_avail),
        .error_non_fatal    (error_non_fatal),
        .mbox_sram_cs       (mbox_sram_cs),
        .mbox_sram_we       (mbox_sram_we),
        .mbox_sram_addr     (mbox_sram_addr),
        .mbox_sram_wdata    (mbox_sram_wdata),
        .mbox_sram_rdata    (mbox_sram_rdata)
    );

endmodule

// ==== verif/mbx_top_chk.sv ====
`timescale 1ns/1ps

module mbx_top_chk (
    input logic clk,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic ready_for_fuses,
    input logic ready_for_mb_processing,
    input logic mbox_sram_cs,
    input logic mbox_sram_we
);

    int ack_fails   = 0;
    int ready_fails = 0;
    int sram_fails  = 0;

    // Registered ack still sees the request it answers
    ack_in_request: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> (wb_cyc && wb_stb))
    else
    begin
        ack_fails++;
        $error("wb_ack high outside an active request");
    end

    ready_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(ready_for_fuses && ready_for_mb_processing))
    else
    begin
        ready_fails++;
        $error("Both ready strobes high together");
    end

    sram_we_with_cs: assert property (@(posedge clk) disable iff (reset)
        mbox_sram_we |-> mbox_sram_cs)
    else
    begin
        sram_fails++;
        $error("mbox_sram_we high without mbox_sram_cs");
    end

endmodule

bind mbx_top mbx_top_chk i_chk (
    .clk                     (clk),
    .reset                   (reset),
    .wb_cyc                  (wb_cyc),
    .wb_stb                  (wb_stb),
    .wb_ack                  (wb_ack),
    .ready_for_fuses         (ready_for_fuses),
    .ready_for_mb_processing (ready_for_mb_processing),
    .mbox_sram_cs            (mbox_sram_cs),
    .mbox_sram_we            (mbox_sram_we)
);

// ==== verif/mbx_top_tb.sv ====
`timescale 1ns/1ps

module mbx_top_tb;

    localparam int    NUM_FUSE_WORDS = 8;
    localparam int    BOOT_CYCLES    = 20;
    localparam int    ACK_TIMEOUT    = 50;
    localparam int    BOOT_TIMEOUT   = 200;
    localparam string CASE_FILE      = "verif/mbx_cases.txt";

    logic                core_clk = 1'b0;
    logic                reset;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    mbx_pkg::wb_addr_t   wb_adr;
    mbx_pkg::wb_data_t   wb_dat_w;
    mbx_pkg::wb_data_t   wb_dat_r;
    logic                wb_ack;
    logic                boot_brkpoint;
    logic                ready_for_fuses;
    logic                ready_for_mb_processing;
    logic                mailbox_data_avail;
    logic                error_non_fatal;
    logic                mbox_sram_cs;
    logic                mbox_sram_we;
    mbx_pkg::sram_addr_t mbox_sram_addr;
    mbx_pkg::wb_data_t   mbox_sram_wdata;
    mbx_pkg::wb_data_t   mbox_sram_rdata = '0;

    // SRAM model state and expected-value copies
    mbx_pkg::wb_data_t   sram_mem [64];
    mbx_pkg::sram_addr_t sram_rd_addr;
    int                  sram_wr_count = 0;
    mbx_pkg::wb_data_t   fuse_shadow [16];
    mbx_pkg::wb_data_t   mbox_q [$];
    mbx_pkg::sram_addr_t din_idx;

    always #50 core_clk = ~core_clk;

    mbx_top #(
        .NUM_FUSE_WORDS (NUM_FUSE_WORDS),
        .BOOT_CYCLES    (BOOT_CYCLES)
    ) i_mbx_top (
        .clk                     (core_clk),
        .reset                   (reset),
        .wb_cyc                  (wb_cyc),
        .wb_stb                  (wb_stb),
        .wb_we                   (wb_we),
        .wb_adr                  (wb_adr),
        .wb_dat_w                (wb_dat_w),
        .wb_dat_r                (wb_dat_r),
        .wb_ack                  (wb_ack),
        .boot_brkpoint           (boot_brkpoint),
        .ready_for_fuses         (ready_for_fuses),
        .ready_for_mb_processing (ready_for_mb_processing),
        .mailbox_data_avail      (mailbox_data_avail),
        .error_non_fatal         (error_non_fatal),
        .mbox_sram_cs            (mbox_sram_cs),
        .mbox_sram_we            (mbox_sram_we),
        .mbox_sram_addr          (mbox_sram_addr),
        .mbox_sram_wdata         (mbox_sram_wdata),
        .mbox_sram_rdata         (mbox_sram_rdata)
    );

    // Mailbox SRAM model with one cycle of read latency
    always @(posedge core_clk)
    begin
        if (mbox_sram_cs && mbox_sram_we)
        begin
            sram_mem[mbox_sram_addr] = mbox_sram_wdata;
            sram_wr_count++;
        end
        else if (mbox_sram_cs)
        begin
            // Address belongs to the edge, the pointer moves right after it
            sram_rd_addr = mbox_sram_addr;
            #1;
            mbox_sram_rdata = sram_mem[sram_rd_addr];
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_data(input mbx_pkg::wb_data_t actual, input mbx_pkg::wb_data_t expected,
                              input string what);
        if (actual !== expected)
        begin
            abort_run($sformatf("FAIL at %0d ns: %s gave 0x%08h, expected 0x%08h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
        begin
            abort_run($sformatf("FAIL at %0d ns: %s is %b, expected %b",
                                $time, what, actual, expected));
        end
    endtask

    // Ack sampled on the falling edge and the request dropped after the next rising edge
    task automatic wait_for_ack(input mbx_pkg::wb_addr_t addr, output mbx_pkg::wb_data_t data);
        int cycles;
        cycles = 0;
        @(negedge core_clk);
        while (!wb_ack)
        begin
            cycles++;
            if (cycles >= ACK_TIMEOUT)
            begin
                abort_run($sformatf("No wb_ack within %0d cycles for address 0x%02h",
                                    ACK_TIMEOUT, addr));
            end
            @(negedge core_clk);
        end
        data = wb_dat_r;
        @(posedge core_clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input mbx_pkg::wb_addr_t addr, input mbx_pkg::wb_data_t data);
        mbx_pkg::wb_data_t ignored;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = addr;
        wb_dat_w = data;
        wait_for_ack(addr, ignored);
    endtask

    task automatic wb_read(input mbx_pkg::wb_addr_t addr, output mbx_pkg::wb_data_t data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = addr;
        wait_for_ack(addr, data);
    endtask

    task automatic run_case(input int op, input mbx_pkg::wb_addr_t addr,
                            input mbx_pkg::wb_data_t wdata, input mbx_pkg::wb_data_t exp);
        mbx_pkg::wb_data_t rdata;
        mbx_pkg::wb_data_t rnd;
        mbx_pkg::wb_data_t want;
        int                cycles;
        case (op)
            0:
            begin
                wb_write(addr, wdata);
                // Execute cleared rewinds both mailbox pointers
                if (addr == mbx_pkg::REG_MBOX_EXECUTE && !wdata[0])
                begin
                    din_idx = '0;
                    mbox_q.delete();
                end
            end
            1:
            begin
                wb_read(addr, rdata);
                check_data(rdata, exp, $sformatf("Read of 0x%02h", addr));
            end
            2:
            begin
                rnd = $urandom;
                wb_write(addr, rnd);
                if (addr == mbx_pkg::REG_MBOX_DATAIN)
                begin
                    check_data(sram_mem[din_idx], rnd, $sformatf("SRAM word %0d", din_idx));
                    mbox_q.push_back(rnd);
                    din_idx++;
                end
                else
                begin
                    fuse_shadow[addr[3:0]] = rnd;
                end
            end
            3:
            begin
                want = '0;
                if (addr != mbx_pkg::REG_MBOX_DATAOUT)
                begin
                    want = fuse_shadow[addr[3:0]];
                end
                else if (mbox_q.size() > 0)
                begin
                    want = mbox_q.pop_front();
                end
                wb_read(addr, rdata);
                check_data(rdata, want, $sformatf("Read of 0x%02h", addr));
            end
            4:
            begin
                case (addr)
                    8'h00:   check_flag(ready_for_fuses, exp[0], "ready_for_fuses");
                    8'h01:   check_flag(ready_for_mb_processing, exp[0], "ready_for_mb_processing");
                    8'h02:   check_flag(mailbox_data_avail, exp[0], "mailbox_data_avail");
                    default: check_flag(error_non_fatal, exp[0], "error_non_fatal");
                endcase
            end
            5:
                boot_brkpoint = wdata[0];
            6:
            begin
                repeat (wdata)
                begin
                    @(posedge core_clk);
                    #1;
                    check_flag(ready_for_mb_processing, exp[0], "ready_for_mb_processing");
                end
            end
            7:
            begin
                // Cycles from breakpoint release to ready_for_mb_processing
                @(posedge core_clk);
                #1;
                boot_brkpoint = 1'b0;
                cycles = 0;
                while (!ready_for_mb_processing)
                begin
                    @(posedge core_clk);
                    #1;
                    cycles++;
                    if (cycles >= BOOT_TIMEOUT)
                    begin
                        abort_run("ready_for_mb_processing never rose after the breakpoint");
                    end
                end
                check_data(mbx_pkg::wb_data_t'(cycles), exp, "Boot release latency");
            end
            8:
                check_data(mbx_pkg::wb_data_t'(sram_wr_count), exp, "SRAM write count");
            default:
                abort_run($sformatf("Unknown operation %0d in the case file", op));
        endcase
    endtask

    initial
    begin
        int                fd;
        int                op;
        mbx_pkg::wb_addr_t addr;
        mbx_pkg::wb_data_t wdata;
        mbx_pkg::wb_data_t exp;
        string             line;
        void'($urandom(32'he4bd));
        reset         = 1'b1;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        boot_brkpoint = 1'b0;
        din_idx       = '0;
        for (int i = 0; i < 64; i++)
        begin
            sram_mem[i[5:0]] = 32'h5a00_0000 + i;
        end
        for (int i = 0; i < 16; i++)
        begin
            fuse_shadow[i[3:0]] = '0;
        end
        repeat (16) @(posedge core_clk);
        #1;
        reset = 1'b0;
        // Boot FSM leaves idle on the first edge out of reset
        @(posedge core_clk);
        #1;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0)
        begin
            abort_run("Could not open the case file");
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#")
            begin
                continue;
            end
            if ($sscanf(line, "%h %h %h %h", op, addr, wdata, exp) != 4)
            begin
                continue;
            end
            run_case(op, addr, wdata, exp);
        end
        $fclose(fd);
        repeat (2) @(posedge core_clk);
        #1;
        if (i_mbx_top.i_chk.ack_fails + i_mbx_top.i_chk.ready_fails
            + i_mbx_top.i_chk.sram_fails != 0)
        begin
            abort_run("The bound protocol checker reported assertion failures");
        end
        else
        begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== verif/mbx_cases.txt ====
# op addr wdata expected, hex. op 0 write, 1 read, 2 random write, 3 read vs random copy
# op 4 flag (0 rdy_fuses 1 rdy_mb 2 avail 3 err), 5 brkpoint, 6 hold cycles, 7 release, 8 SRAM writes
4 00 00000000 00000001
4 01 00000000 00000000
1 11 00000000 00000001
2 00 00000000 00000000
2 03 00000000 00000000
2 07 00000000 00000000
3 00 00000000 00000000
3 03 00000000 00000000
3 07 00000000 00000000
1 08 00000000 00000000
1 0f 00000000 00000000
1 12 00000000 00000001
5 00 00000001 00000000
0 10 00000001 00000000
0 03 0badf00d 00000000
3 03 00000000 00000000
4 03 00000000 00000001
1 11 00000000 00000010
1 17 00000000 00000001
0 17 00000000 00000000
1 11 00000000 00000000
6 00 00000064 00000000
7 00 00000000 00000015
1 11 00000000 00000002
1 12 00000000 00000000
1 12 00000000 00000001
1 11 00000000 00000006
0 13 00000003 00000000
2 14 00000000 00000000
2 14 00000000 00000000
2 14 00000000 00000000
0 16 00000001 00000000
4 02 00000000 00000001
3 15 00000000 00000000
3 15 00000000 00000000
3 15 00000000 00000000
3 15 00000000 00000000
0 16 00000000 00000000
4 02 00000000 00000000
1 12 00000000 00000000
0 16 00000000 00000000
0 14 bad0bad0 00000000
4 03 00000000 00000001
8 00 00000000 00000003
1 11 00000000 00000012

// ==== list.f ====
verilog/mbx_pkg.sv
verilog/mbx_wb_slave.sv
verilog/mbx_fuse_bank.sv
verilog/mbx_boot_fsm.sv
verilog/mbx_mailbox.sv
verilog/mbx_top.sv
verif/mbx_top_chk.sv
verif/mbx_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module mbx_top_tb -o mbx_sim

sim_out=$(./obj_dir/mbx_sim +verilator+error+limit+100) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q '^TEST OK$'; then
    exit 0
fi
exit 1
